//--- hdl/rob_cfg_pkg.sv
/*
  reorder buffer sizing shared by the design and testbench
  index, pointer and occupancy types derive from ROB_DEPTH
*/
package rob_cfg_pkg;

  // ==========================================================================
  // sizes
  // ==========================================================================
  localparam int ROB_DEPTH  = 16;
  localparam int DISP_WIDTH = 2;
  localparam int CMT_WIDTH  = 2;

  // derived widths
  localparam int IDX_W = $clog2(ROB_DEPTH);
  localparam int PTR_W = IDX_W + 1;

  // ==========================================================================
  // types
  // ==========================================================================
  // entry index into the buffer
  typedef logic [IDX_W-1:0] rob_idx_t;

  // index plus wrap bit
  typedef logic [PTR_W-1:0] rob_ptr_t;

  // occupancy, reaches ROB_DEPTH when full
  typedef logic [PTR_W-1:0] rob_cnt_t;

endpackage

//--- hdl/rob_op_pkg.sv
/*
  instruction level definitions: pc type, class codes
  and the exception vector used as flush target
*/
package rob_op_pkg;

  // instruction address
  typedef logic [31:0] pc_t;

  // instruction class
  typedef logic [1:0] rob_type_t;

  // ==========================================================================
  // class codes
  // ==========================================================================
  localparam rob_type_t TYPE_ALU = 2'd0;
  localparam rob_type_t TYPE_BR  = 2'd1;
  localparam rob_type_t TYPE_MEM = 2'd2;

  // ==========================================================================
  // flush targets
  // ==========================================================================
  // all exceptions redirect here
  localparam pc_t EXC_VECTOR = 32'h0000_0180;

endpackage

//--- hdl/alloc_if.sv
/*
  two-slot allocation group from the dispatch stage into the reorder buffer
  a group moves at the edge where ready is high and any valid bit is set
*/
`timescale 1ns/100ps

interface alloc_if
  import rob_cfg_pkg::*, rob_op_pkg::*;
();

  logic      [DISP_WIDTH-1:0] valid;
  pc_t       [DISP_WIDTH-1:0] pc;
  rob_type_t [DISP_WIDTH-1:0] itype;
  logic      [DISP_WIDTH-1:0] excp;
  // buffer has room for a full group
  logic                       ready;

  modport disp (
    output valid, pc, itype, excp,
    input  ready
  );

  modport rob (
    input  valid, pc, itype, excp,
    output ready
  );

endinterface

//--- hdl/wb_if.sv
/*
  one alu write-back port into the reorder buffer
  always accepted, so it has no ready
*/
`timescale 1ns/100ps

interface wb_if
  import rob_cfg_pkg::*, rob_op_pkg::*;
();

  logic     valid;
  rob_idx_t rob_idx;
  // branch mispredicted, target holds the fetch address to resume at
  logic     redirect;
  pc_t      target;

  modport src (
    output valid, rob_idx, redirect, target
  );

  modport rob (
    input  valid, rob_idx, redirect, target
  );

endinterface

//--- hdl/cmt_if.sv
/*
  two commit slots from the reorder buffer into the retire stage
  slots are consumed at the next edge, flush comes back in the same cycle
*/
`timescale 1ns/100ps

interface cmt_if
  import rob_cfg_pkg::*, rob_op_pkg::*;
();

  logic [CMT_WIDTH-1:0] valid;
  pc_t  [CMT_WIDTH-1:0] pc;
  logic [CMT_WIDTH-1:0] excp;
  logic [CMT_WIDTH-1:0] redirect;
  pc_t  [CMT_WIDTH-1:0] target;
  logic                 flush;

  modport rob (
    output valid, pc, excp, redirect, target,
    input  flush
  );

  modport ret (
    input  valid, pc, excp, redirect, target,
    output flush
  );

endinterface

//--- hdl/rob_dispatch.sv
/*
  dispatch register stage between decode and the reorder buffer
  holds one decode group while the buffer is full, emptied by a flush
*/
`timescale 1ns/100ps

module rob_dispatch
  import rob_cfg_pkg::*, rob_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // decode side
  input  logic      [DISP_WIDTH-1:0] in_valid,
  input  pc_t       [DISP_WIDTH-1:0] in_pc,
  input  rob_type_t [DISP_WIDTH-1:0] in_type,
  input  logic      [DISP_WIDTH-1:0] in_excp,
  output logic                       in_ready,
  // toward the buffer
  alloc_if.disp                      alloc,
  input  logic                       flush
);

  logic [DISP_WIDTH-1:0] valid_q;
  logic                  run_q;
  logic                  empty;
  logic                  take;

  // ==========================================================================
  // handshake
  // ==========================================================================
  assign empty    = ~|valid_q;
  assign take     = alloc.ready & ~empty;
  // new fetch is not accepted while the pipeline flushes
  assign in_ready = run_q & ~flush & (empty | take);

  // ==========================================================================
  // group register
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q   <= 1'b0;
      valid_q <= '0;
    end else begin
      run_q <= 1'b1;
      if (flush) begin
        valid_q <= '0;
      end else if (in_ready) begin
        valid_q <= in_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready && |in_valid) begin
      alloc.pc    <= in_pc;
      alloc.itype <= in_type;
      alloc.excp  <= in_excp;
    end
  end

  assign alloc.valid = valid_q;

endmodule

//--- hdl/rob_buffer.sv
/*
  16-entry reorder buffer: in-order allocation, out-of-order write-back
  and selection of up to two in-order commit slots per cycle
*/
`timescale 1ns/100ps

module rob_buffer
  import rob_cfg_pkg::*, rob_op_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  alloc_if.rob     alloc,
  wb_if.rob        wb0,
  wb_if.rob        wb1,
  // memory write-back
  input  logic     mem_valid,
  input  rob_idx_t mem_idx,
  input  logic     mem_is_store,
  input  logic     mem_excp,
  output logic     mem_ready,
  cmt_if.rob       cmt
);

  // ==========================================================================
  // entry storage and pointers
  // ==========================================================================
  pc_t                  pc_q    [ROB_DEPTH];
  rob_type_t            type_q  [ROB_DEPTH];
  pc_t                  tgt_q   [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] cmpl_q;
  logic [ROB_DEPTH-1:0] excp_q;
  logic [ROB_DEPTH-1:0] redir_q;

  rob_ptr_t head_q;
  rob_ptr_t tail_q;
  rob_cnt_t cnt_q;
  logic     run_q;

  rob_idx_t                 head_idx;
  rob_idx_t                 tail_idx;
  rob_idx_t [DISP_WIDTH-1:0] alloc_idx;
  rob_idx_t [CMT_WIDTH-1:0]  cmt_idx;
  logic                     alloc_take;
  rob_cnt_t                 alloc_n;
  rob_cnt_t                 cmt_n;
  logic                     mem_take;
  logic                     slot1_blk;

  assign head_idx = head_q[IDX_W-1:0];
  assign tail_idx = tail_q[IDX_W-1:0];

  // ==========================================================================
  // allocation
  // ==========================================================================
  // room for a whole group, nothing enters during a flush
  assign alloc.ready = run_q & ~cmt.flush & (cnt_q <= rob_cnt_t'(ROB_DEPTH - DISP_WIDTH));
  assign alloc_take  = alloc.ready & |alloc.valid;

  // only valid slots consume an index
  assign alloc_idx[0] = tail_idx;
  assign alloc_idx[1] = tail_idx + rob_idx_t'(alloc.valid[0]);
  assign alloc_n = alloc_take ?
                   rob_cnt_t'(alloc.valid[0]) + rob_cnt_t'(alloc.valid[1]) : '0;

  // stores wait until they are the oldest entry
  assign mem_ready = run_q & (~mem_is_store | (mem_idx == head_idx));
  assign mem_take  = mem_valid & mem_ready;

  // ==========================================================================
  // commit selection
  // ==========================================================================
  assign cmt_idx[0] = head_idx;
  assign cmt_idx[1] = head_idx + rob_idx_t'(1);

  // one branch per group, nothing behind a redirect or exception
  assign slot1_blk = (type_q[cmt_idx[0]] == TYPE_BR) | redir_q[cmt_idx[0]] |
                     excp_q[cmt_idx[0]];

  assign cmt.valid[0] = (cnt_q != '0) & cmpl_q[cmt_idx[0]];
  assign cmt.valid[1] = cmt.valid[0] & (cnt_q >= rob_cnt_t'(2)) &
                        cmpl_q[cmt_idx[1]] & ~slot1_blk;

  always_comb begin
    for (int i = 0; i < CMT_WIDTH; i++) begin
      cmt.pc[i]       = pc_q[cmt_idx[i]];
      cmt.excp[i]     = excp_q[cmt_idx[i]];
      cmt.redirect[i] = redir_q[cmt_idx[i]];
      cmt.target[i]   = tgt_q[cmt_idx[i]];
    end
  end

  assign cmt_n = rob_cnt_t'(cmt.valid[0]) + rob_cnt_t'(cmt.valid[1]);

  // ==========================================================================
  // pointers and completion state
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      run_q  <= 1'b0;
      head_q <= '0;
      tail_q <= '0;
      cnt_q  <= '0;
      cmpl_q <= '0;
    end else begin
      run_q <= 1'b1;
      for (int i = 0; i < DISP_WIDTH; i++) begin
        // known exception counts as already executed
        if (alloc_take && alloc.valid[i]) begin
          cmpl_q[alloc_idx[i]] <= alloc.excp[i];
        end
      end
      if (wb0.valid) begin
        cmpl_q[wb0.rob_idx] <= 1'b1;
      end
      if (wb1.valid) begin
        cmpl_q[wb1.rob_idx] <= 1'b1;
      end
      if (mem_take) begin
        cmpl_q[mem_idx] <= 1'b1;
      end
      if (cmt.flush) begin
        head_q <= '0;
        tail_q <= '0;
        cnt_q  <= '0;
      end else begin
        head_q <= head_q + rob_ptr_t'(cmt_n);
        tail_q <= tail_q + rob_ptr_t'(alloc_n);
        cnt_q  <= cnt_q + alloc_n - cmt_n;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    for (int i = 0; i < DISP_WIDTH; i++) begin
      if (alloc_take && alloc.valid[i]) begin
        pc_q[alloc_idx[i]]    <= alloc.pc[i];
        type_q[alloc_idx[i]]  <= alloc.itype[i];
        excp_q[alloc_idx[i]]  <= alloc.excp[i];
        redir_q[alloc_idx[i]] <= 1'b0;
      end
    end
    if (wb0.valid) begin
      redir_q[wb0.rob_idx] <= wb0.redirect;
      tgt_q[wb0.rob_idx]   <= wb0.target;
    end
    if (wb1.valid) begin
      redir_q[wb1.rob_idx] <= wb1.redirect;
      tgt_q[wb1.rob_idx]   <= wb1.target;
    end
    if (mem_take) begin
      excp_q[mem_idx]  <= mem_excp;
      redir_q[mem_idx] <= 1'b0;
    end
  end

endmodule

//--- hdl/rob_retire.sv
/*
  retire stage: decides the pipeline flush from the commit slots
  and registers the retire group together with the flush request
*/
`timescale 1ns/100ps

module rob_retire
  import rob_cfg_pkg::*, rob_op_pkg::*;
(
  input  logic                 clk,
  input  logic                 rst_n,
  cmt_if.ret                   cmt,
  output logic [CMT_WIDTH-1:0] ret_valid,
  output pc_t  [CMT_WIDTH-1:0] ret_pc,
  output logic [CMT_WIDTH-1:0] ret_excp,
  output logic                 flush_o,
  output pc_t                  flush_pc
);

  logic [CMT_WIDTH-1:0] slot_flush;
  pc_t                  flush_tgt;

  // ==========================================================================
  // flush decision
  // ==========================================================================
  assign slot_flush = cmt.valid & (cmt.excp | cmt.redirect);
  assign cmt.flush  = |slot_flush;

  // slot 0 is older, so it wins
  always_comb begin
    if (slot_flush[0]) begin
      flush_tgt = cmt.excp[0] ? EXC_VECTOR : cmt.target[0];
    end else begin
      flush_tgt = cmt.excp[1] ? EXC_VECTOR : cmt.target[1];
    end
  end

  // ==========================================================================
  // retire registers
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ret_valid <= '0;
      ret_excp  <= '0;
      flush_o   <= 1'b0;
    end else begin
      ret_valid <= cmt.valid;
      ret_excp  <= cmt.valid & cmt.excp;
      flush_o   <= cmt.flush;
    end
  end

  always_ff @(posedge clk) begin
    ret_pc   <= cmt.pc;
    flush_pc <= flush_tgt;
  end

endmodule

//--- hdl/rob_core_top.sv
/*
  retirement side of a two-wide core: dispatch register, reorder buffer
  and retire stage, with execution units attached through plain ports
*/
`timescale 1ns/100ps

module rob_core_top
  import rob_cfg_pkg::*, rob_op_pkg::*;
(
  input  logic                       clk,
  input  logic                       rst_n,
  // decode group
  input  logic      [DISP_WIDTH-1:0] in_valid,
  input  pc_t       [DISP_WIDTH-1:0] in_pc,
  input  rob_type_t [DISP_WIDTH-1:0] in_type,
  input  logic      [DISP_WIDTH-1:0] in_excp,
  output logic                       in_ready,
  // alu write-back ports
  input  logic                       wb0_valid,
  input  rob_idx_t                   wb0_idx,
  input  logic                       wb0_redirect,
  input  pc_t                        wb0_target,
  input  logic                       wb1_valid,
  input  rob_idx_t                   wb1_idx,
  input  logic                       wb1_redirect,
  input  pc_t                        wb1_target,
  // memory write-back
  input  logic                       mem_valid,
  input  rob_idx_t                   mem_idx,
  input  logic                       mem_is_store,
  input  logic                       mem_excp,
  output logic                       mem_ready,
  // retire
  output logic      [CMT_WIDTH-1:0]  ret_valid,
  output pc_t       [CMT_WIDTH-1:0]  ret_pc,
  output logic      [CMT_WIDTH-1:0]  ret_excp,
  output logic                       flush,
  output pc_t                        flush_pc
);

  alloc_if alloc ();
  wb_if    wb0 ();
  wb_if    wb1 ();
  cmt_if   cmt ();

  assign wb0.valid    = wb0_valid;
  assign wb0.rob_idx  = wb0_idx;
  assign wb0.redirect = wb0_redirect;
  assign wb0.target   = wb0_target;
  assign wb1.valid    = wb1_valid;
  assign wb1.rob_idx  = wb1_idx;
  assign wb1.redirect = wb1_redirect;
  assign wb1.target   = wb1_target;

  // ==========================================================================
  // stages
  // ==========================================================================
  rob_dispatch u_dispatch (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .in_pc    (in_pc),
    .in_type  (in_type),
    .in_excp  (in_excp),
    .in_ready (in_ready),
    .alloc    (alloc.disp),
    .flush    (cmt.flush)
  );

  rob_buffer u_buffer (
    .clk          (clk),
    .rst_n        (rst_n),
    .alloc        (alloc.rob),
    .wb0          (wb0.rob),
    .wb1          (wb1.rob),
    .mem_valid    (mem_valid),
    .mem_idx      (mem_idx),
    .mem_is_store (mem_is_store),
    .mem_excp     (mem_excp),
    .mem_ready    (mem_ready),
    .cmt          (cmt.rob)
  );

  rob_retire u_retire (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmt       (cmt.ret),
    .ret_valid (ret_valid),
    .ret_pc    (ret_pc),
    .ret_excp  (ret_excp),
    .flush_o   (flush),
    .flush_pc  (flush_pc)
  );

endmodule

//--- dv/rob_ref.svh
/*
  reference model of the reorder buffer, included inside the testbench module
  queues hold instructions oldest first, allocated ones ahead of pending ones
*/
`ifndef ROB_REF_SVH
`define ROB_REF_SVH

pc_t       q_pc    [$];
rob_type_t q_type  [$];
logic      q_excp  [$];
logic      q_cmpl  [$];
logic      q_redir [$];
pc_t       q_tgt   [$];
rob_idx_t  q_idx   [$];
logic      q_alloc [$];

function automatic int alloc_count();
  int n;
  n = 0;
  foreach (q_alloc[i]) begin
    if (q_alloc[i]) begin
      n++;
    end
  end
  return n;
endfunction

function automatic void push_entry(pc_t pc, rob_type_t t, logic e, rob_idx_t idx);
  q_pc.push_back(pc);
  q_type.push_back(t);
  q_excp.push_back(e);
  q_cmpl.push_back(1'b0);
  q_redir.push_back(1'b0);
  q_tgt.push_back('0);
  q_idx.push_back(idx);
  q_alloc.push_back(1'b0);
endfunction

function automatic void pop_entry();
  void'(q_pc.pop_front());
  void'(q_type.pop_front());
  void'(q_excp.pop_front());
  void'(q_cmpl.pop_front());
  void'(q_redir.pop_front());
  void'(q_tgt.pop_front());
  void'(q_idx.pop_front());
  void'(q_alloc.pop_front());
endfunction

function automatic void clear_all();
  while (q_pc.size() > 0) begin
    pop_entry();
  end
endfunction

// pending group enters the buffer, known exceptions start complete
function automatic void allocate_pending();
  foreach (q_alloc[i]) begin
    if (!q_alloc[i]) begin
      q_alloc[i] = 1'b1;
      q_cmpl[i]  = q_excp[i];
    end
  end
endfunction

function automatic void mark_done(rob_idx_t idx, logic mem, logic e, logic r, pc_t t);
  foreach (q_idx[i]) begin
    if (q_alloc[i] && q_idx[i] == idx) begin
      q_cmpl[i]  = 1'b1;
      q_redir[i] = r;
      if (mem) begin
        q_excp[i] = e;
      end else begin
        q_tgt[i] = t;
      end
    end
  end
endfunction

function automatic rob_idx_t idx_of_pc(pc_t pc);
  foreach (q_pc[i]) begin
    if (q_pc[i] == pc) begin
      return q_idx[i];
    end
  end
  return '0;
endfunction

// ==========================================================================
// expected commit group from the oldest entries
// ==========================================================================
function automatic logic [1:0] ref_group();
  logic [1:0] v;
  v = 2'b00;
  if (alloc_count() >= 1 && q_cmpl[0]) begin
    v[0] = 1'b1;
  end
  if (v[0] && alloc_count() >= 2 && q_cmpl[1] && q_type[0] != TYPE_BR &&
      !q_redir[0] && !q_excp[0]) begin
    v[1] = 1'b1;
  end
  return v;
endfunction

function automatic logic ref_flush(logic [1:0] v);
  return (v[0] && (q_excp[0] || q_redir[0])) || (v[1] && (q_excp[1] || q_redir[1]));
endfunction

function automatic pc_t ref_flush_pc(logic [1:0] v);
  if (v[0] && (q_excp[0] || q_redir[0])) begin
    return q_excp[0] ? EXC_VECTOR : q_tgt[0];
  end
  if (v[1]) begin
    return q_excp[1] ? EXC_VECTOR : q_tgt[1];
  end
  return '0;
endfunction

`endif

//--- dv/rob_core_tb.sv
/*
  testbench for rob_core_top: stands in for decode and the execution units
  and checks every retire group and flush against the reference model
*/
`timescale 1ns/100ps

module rob_core_tb
  import rob_cfg_pkg::*, rob_op_pkg::*;
();

  localparam int TIMEOUT = 400;

  logic                       clk;
  logic                       rst_n;
  logic      [DISP_WIDTH-1:0] in_valid;
  pc_t       [DISP_WIDTH-1:0] in_pc;
  rob_type_t [DISP_WIDTH-1:0] in_type;
  logic      [DISP_WIDTH-1:0] in_excp;
  logic                       in_ready;
  logic                       wb0_valid, wb1_valid;
  rob_idx_t                   wb0_idx, wb1_idx;
  logic                       wb0_redirect, wb1_redirect;
  pc_t                        wb0_target, wb1_target;
  logic                       mem_valid, mem_is_store, mem_excp, mem_ready;
  rob_idx_t                   mem_idx;
  logic      [CMT_WIDTH-1:0]  ret_valid, ret_excp;
  pc_t       [CMT_WIDTH-1:0]  ret_pc;
  logic                       flush;
  pc_t                        flush_pc;

  `include "rob_ref.svh"

  integer     seed = 32'h4dd7;
  logic       wb_en;
  logic       mon_on;
  pc_t        next_pc;
  int         idx_ctr;
  int         ret_ctr;
  // g1 holds the group selected after the last edge and g2 the one before it
  logic [1:0] g1_v, g2_v, g1_e, g2_e;
  pc_t  [1:0] g1_pc, g2_pc;
  logic       g1_f, g2_f;
  pc_t        g1_fpc, g2_fpc;

  rob_core_top u_dut (.*);

  always #2 clk = ~clk;

  // ==========================================================================
  // check tasks
  // ==========================================================================
  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic timeout_abort(string what);
    $display("timeout while waiting for %s", what);
    stop_run();
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_pc(string name, pc_t got, pc_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_idx(string name, rob_idx_t got, rob_idx_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // ==========================================================================
  // compare process and model update
  // ==========================================================================
  always @(posedge clk) begin
    if (mon_on) begin
      for (int i = 0; i < CMT_WIDTH; i++) begin
        check_bit($sformatf("ret_valid[%0d]", i), ret_valid[i], g2_v[i]);
        check_bit($sformatf("ret_excp[%0d]", i), ret_excp[i], g2_v[i] & g2_e[i]);
        if (g2_v[i]) begin
          check_pc($sformatf("ret_pc[%0d]", i), ret_pc[i], g2_pc[i]);
        end
      end
      check_bit("flush", flush, g2_f);
      if (g2_f) begin
        check_pc("flush_pc", flush_pc, g2_fpc);
      end
      check_bit("in_ready", in_ready, !g1_f &&
                (q_pc.size() == alloc_count() || alloc_count() <= ROB_DEPTH - DISP_WIDTH));
      if (mem_valid) begin
        check_bit("mem_ready", mem_ready,
                  !mem_is_store || (alloc_count() > 0 && mem_idx == q_idx[0]));
      end
      // head entry before the commits of this edge
      check_idx("head index", u_dut.u_buffer.head_idx, rob_idx_t'(ret_ctr));
      // commit at this edge
      for (int i = 0; i < CMT_WIDTH; i++) begin
        if (g1_v[i]) begin
          ret_ctr = (ret_ctr + 1) % ROB_DEPTH;
          pop_entry();
        end
      end
      if (g1_f) begin
        clear_all();
        idx_ctr = 0;
        ret_ctr = 0;
      end else begin
        if (wb0_valid) mark_done(wb0_idx, 1'b0, 1'b0, wb0_redirect, wb0_target);
        if (wb1_valid) mark_done(wb1_idx, 1'b0, 1'b0, wb1_redirect, wb1_target);
        if (mem_valid && mem_ready) mark_done(mem_idx, 1'b1, mem_excp, 1'b0, '0);
        if (in_ready) begin
          allocate_pending();
          for (int i = 0; i < DISP_WIDTH; i++) begin
            if (in_valid[i]) begin
              push_entry(in_pc[i], in_type[i], in_excp[i], rob_idx_t'(idx_ctr));
              idx_ctr = (idx_ctr + 1) % ROB_DEPTH;
            end
          end
        end
      end
      g2_v   = g1_v;
      g2_e   = g1_e;
      g2_pc  = g1_pc;
      g2_f   = g1_f;
      g2_fpc = g1_fpc;
      g1_v = ref_group();
      g1_f = ref_flush(g1_v);
      g1_fpc = ref_flush_pc(g1_v);
      for (int i = 0; i < CMT_WIDTH; i++) begin
        g1_pc[i] = (q_pc.size() > i) ? q_pc[i] : '0;
        g1_e[i]  = (q_pc.size() > i) ? q_excp[i] : 1'b0;
      end
    end
  end

  // ==========================================================================
  // stimulus helpers that drive on the falling edge
  // ==========================================================================
  task automatic random_writeback();
    int cand[$];
    int a;
    foreach (q_pc[i]) begin
      if (q_alloc[i] && !q_cmpl[i] && q_type[i] != TYPE_MEM) cand.push_back(i);
    end
    if (cand.size() > 0 && $random(seed) & 1) begin
      a = $unsigned($random(seed)) % cand.size();
      wb0_valid    = 1'b1;
      wb0_idx      = q_idx[cand[a]];
      wb0_redirect = 1'b0;
      cand.delete(a);
    end
    if (cand.size() > 0 && $random(seed) & 1) begin
      a = $unsigned($random(seed)) % cand.size();
      wb1_valid    = 1'b1;
      wb1_idx      = q_idx[cand[a]];
      wb1_redirect = 1'b0;
    end
  endtask

  task automatic step();
    @(negedge clk);
    in_valid  = '0;
    wb0_valid = 1'b0;
    wb1_valid = 1'b0;
    if (wb_en) random_writeback();
  endtask

  task automatic send_group(logic [1:0] v, rob_type_t t0, logic e0, rob_type_t t1, logic e1);
    int n;
    n = 0;
    step();
    while (!in_ready) begin
      n++;
      if (n > TIMEOUT) timeout_abort("in_ready");
      step();
    end
    in_valid   = v;
    in_pc[0]   = next_pc;
    in_type[0] = t0;
    in_excp[0] = e0;
    in_pc[1]   = next_pc + 4;
    in_type[1] = t1;
    in_excp[1] = e1;
    next_pc = next_pc + 8;
  endtask

  task automatic wait_allocated();
    int n;
    n = 0;
    step();
    while (alloc_count() != q_pc.size()) begin
      n++;
      if (n > TIMEOUT) timeout_abort("allocation of the dispatched groups");
      step();
    end
  endtask

  task automatic wait_mem_taken();
    int n;
    n = 0;
    while (!mem_ready) begin
      n++;
      if (n > TIMEOUT) timeout_abort("mem_ready");
      step();
    end
    step();
    mem_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (q_pc.size() > 0 || g1_v != 0 || g2_v != 0 || ret_valid != 0) begin
      n++;
      if (n > TIMEOUT) timeout_abort("ret_valid to drain the buffer");
      step();
    end
  endtask

  // ==========================================================================
  // tests
  // ==========================================================================
  initial begin
    pc_t a_pc;
    int  n;
    clk     = 0;
    rst_n   = 0;
    mon_on  = 0;
    wb_en   = 0;
    next_pc = 32'h1000;
    idx_ctr = 0;
    ret_ctr = 0;
    g1_v   = 0;
    g2_v   = 0;
    g1_e   = 0;
    g2_e   = 0;
    g1_f   = 0;
    g2_f   = 0;
    g1_pc  = '0;
    g2_pc  = '0;
    g1_fpc = '0;
    g2_fpc = '0;
    in_valid = '0;
    in_pc    = '0;
    in_type  = '0;
    in_excp  = '0;
    wb0_valid    = 0;
    wb0_idx      = '0;
    wb0_redirect = 0;
    wb0_target   = '0;
    wb1_valid    = 0;
    wb1_idx      = '0;
    wb1_redirect = 0;
    wb1_target   = '0;
    mem_valid    = 0;
    mem_idx      = '0;
    mem_is_store = 0;
    mem_excp     = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1;
    step();
    mon_on = 1;

    // out-of-order write-back with in-order retirement
    wb_en = 1;
    repeat (20) begin
      n = $unsigned($random(seed)) % 3 + 1;
      send_group(n[1:0], TYPE_ALU, 1'b0, TYPE_ALU, 1'b0);
    end
    drain();

    // branch pairs
    repeat (6) send_group(2'b11, TYPE_BR, 1'b0, TYPE_BR, 1'b0);
    drain();

    // redirect flush drops the younger group
    wb_en = 0;
    a_pc = next_pc;
    send_group(2'b11, TYPE_ALU, 1'b0, TYPE_BR, 1'b0);
    send_group(2'b11, TYPE_ALU, 1'b0, TYPE_ALU, 1'b0);
    wait_allocated();
    wb0_valid    = 1;
    wb0_idx      = idx_of_pc(a_pc);
    wb0_redirect = 0;
    step();
    wb0_valid    = 1;
    wb0_idx      = idx_of_pc(a_pc + 8);
    wb0_redirect = 0;
    wb1_valid    = 1;
    wb1_idx      = idx_of_pc(a_pc + 12);
    wb1_redirect = 0;
    step();
    wb0_valid    = 1;
    wb0_idx      = idx_of_pc(a_pc + 4);
    wb0_redirect = 1;
    wb0_target   = 32'h0000_4000;
    n = 0;
    while (!flush) begin
      n++;
      if (n > TIMEOUT) timeout_abort("the redirect flush");
      step();
    end
    wb_en = 1;
    send_group(2'b11, TYPE_ALU, 1'b0, TYPE_ALU, 1'b0);
    drain();

    // exception known at dispatch, then a memory exception
    send_group(2'b11, TYPE_ALU, 1'b1, TYPE_ALU, 1'b0);
    drain();
    wb_en = 0;
    a_pc = next_pc;
    send_group(2'b11, TYPE_MEM, 1'b0, TYPE_ALU, 1'b0);
    wait_allocated();
    mem_valid    = 1;
    mem_idx      = idx_of_pc(a_pc);
    mem_is_store = 0;
    mem_excp     = 1;
    wait_mem_taken();
    wb_en = 1;
    drain();

    // store waits for the head
    wb_en = 0;
    a_pc = next_pc;
    send_group(2'b11, TYPE_ALU, 1'b0, TYPE_MEM, 1'b0);
    wait_allocated();
    mem_valid    = 1;
    mem_idx      = idx_of_pc(a_pc + 4);
    mem_is_store = 1;
    mem_excp     = 0;
    repeat (3) step();
    check_bit("mem_ready", mem_ready, 1'b0);
    wb_en = 1;
    wait_mem_taken();
    mem_is_store = 0;
    drain();

    // fill the buffer without write-back
    wb_en = 0;
    repeat (9) send_group(2'b11, TYPE_ALU, 1'b0, TYPE_ALU, 1'b0);
    step();
    step();
    check_bit("in_ready", in_ready, 1'b0);
    wb_en = 1;
    send_group(2'b11, TYPE_ALU, 1'b0, TYPE_ALU, 1'b0);
    drain();

    $display("All tests passed");
    $finish;
  end

endmodule

//--- rob_core.f
+incdir+dv
hdl/rob_cfg_pkg.sv
hdl/rob_op_pkg.sv
hdl/alloc_if.sv
hdl/wb_if.sv
hdl/cmt_if.sv
hdl/rob_dispatch.sv
hdl/rob_buffer.sv
hdl/rob_retire.sv
hdl/rob_core_top.sv
dv/rob_core_tb.sv

//--- Bender.yml
package:
  name: rob_core

sources:
  - hdl/rob_cfg_pkg.sv
  - hdl/rob_op_pkg.sv
  - hdl/alloc_if.sv
  - hdl/wb_if.sv
  - hdl/cmt_if.sv
  - hdl/rob_dispatch.sv
  - hdl/rob_buffer.sv
  - hdl/rob_retire.sv
  - hdl/rob_core_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/rob_core_tb.sv
